// ==== sim/mylstar_vectors.hex ====
// kind frame a b c, kind 0 ends the list
// 1 ROM byte (a addr, b data), 2 host write (a addr, b data), 4 flip pins (a hflip, b vflip)
// 3 expected pixel (a x, b y, c colour as 4-bit red green blue)
1 0 0020 21 0
1 0 0025 43 0
1 0 0044 5a 0
1 0 005b 3f 0
1 0 2020 54 0
1 0 2044 10 0
2 0 4000 01 0
2 0 4021 02 0
2 0 4040 01 0
2 0 5002 23 0
2 0 5003 91 0
2 0 5004 56 0
2 0 5005 04 0
2 0 5006 89 0
2 0 5007 07 0
2 0 5008 bc 0
2 0 5009 0a 0
2 0 500a ef 0
2 0 500b 0d 0
3 0 00 00 123
3 0 01 00 456
3 0 02 01 789
3 0 03 01 abc
3 0 09 09 def
3 0 0f 0e 789
2 1 5003 0c 0
3 1 00 00 c23
3 1 01 00 456
2 2 5002 9a 0
3 2 00 00 c9a
3 2 01 00 456
2 3 5800 02 0
3 3 ff 00 c9a
3 3 fe 00 456
3 3 fd 01 789
3 3 f6 09 def
3 3 f0 0e 789
2 4 5800 06 0
4 4 1 0 0
3 4 00 ef c9a
3 4 01 ef 456
3 4 02 ee 789
3 4 03 ee abc
2 5 5800 10 0
4 5 0 0 0
3 5 00 00 abc
3 5 01 00 def
3 5 09 09 c9a
0 0 0 0 0

// ==== tb.f ====
common/mylstar_pkg.sv
src/video_timing.sv
src/host_decode.sv
bg/bg_tile_render.sv
src/palette_lut.sv
src/mylstar_video.sv
sim/mylstar_video_chk.sv
sim/tb_mylstar_video.sv

// ==== sim/tb_mylstar_video.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mylstar_video
  import mylstar_pkg::*;
();

  localparam int CLK_PERIOD = 20;
  localparam int MAX_WORDS  = 1024;
  localparam int MAX_EXP    = 64;
  localparam int REC_WORDS  = 5;

  logic       clk_sys;
  logic       rst_n;
  host_wr_t   host;
  rom_load_t  rom_load;
  logic       hflip;
  logic       vflip;
  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;
  logic       hsync;
  logic       vsync;
  logic       hblank;
  logic       vblank;

  // Records of kind, frame and three arguments
  logic [31:0] vec_mem [MAX_WORDS];
  int          n_rec = 0;
  int          n_frames = 0;
  logic        vectors_ready = 1'b0;

  int          exp_frame [MAX_EXP];
  int          exp_x [MAX_EXP];
  int          exp_y [MAX_EXP];
  logic [11:0] exp_rgb [MAX_EXP];
  bit          exp_seen [MAX_EXP];
  int          n_exp = 0;

  int errors = 0;
  int checks = 0;

  // Screen position rebuilt from the blanking edges
  int   cap_frame = -1;
  int   x_pos = 0;
  int   y_pos = 0;
  int   cycle = 0;
  int   last_hsync = -1;
  int   last_vsync = -1;
  int   active_len = 0;
  bit   line_open = 1'b0;
  logic prev_hblank = 1'b0;
  logic prev_vblank = 1'b0;
  logic prev_hsync = 1'b0;
  logic prev_vsync = 1'b0;

  always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

  mylstar_video DUT (
    .clk_sys  (clk_sys),
    .rst_n    (rst_n),
    .host     (host),
    .rom_load (rom_load),
    .hflip    (hflip),
    .vflip    (vflip),
    .red      (red),
    .green    (green),
    .blue     (blue),
    .hsync    (hsync),
    .vsync    (vsync),
    .hblank   (hblank),
    .vblank   (vblank)
  );

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic load_vectors();
    int w;
    w = 0;
    $readmemh("sim/mylstar_vectors.hex", vec_mem);
    while (w + REC_WORDS <= MAX_WORDS && !$isunknown(vec_mem[w]) && vec_mem[w] != 0) begin
      if (int'(vec_mem[w+1]) + 1 > n_frames) begin
        n_frames = int'(vec_mem[w+1]) + 1;
      end
      if (vec_mem[w] == 3 && n_exp < MAX_EXP) begin
        exp_frame[n_exp] = int'(vec_mem[w+1]);
        exp_x[n_exp]     = int'(vec_mem[w+2]);
        exp_y[n_exp]     = int'(vec_mem[w+3]);
        exp_rgb[n_exp]   = vec_mem[w+4][11:0];
        exp_seen[n_exp]  = 1'b0;
        n_exp++;
      end
      n_rec++;
      w += REC_WORDS;
    end
  endtask

  // ROM bytes, host writes and pin settings that precede frame f
  task automatic apply_setup(input int f);
    int w;
    for (w = 0; w < n_rec * REC_WORDS; w += REC_WORDS) begin
      if (vec_mem[w+1] == f) begin
        case (vec_mem[w])
          1: begin
            @(posedge clk_sys);
            rom_load <= {1'b1, vec_mem[w+2][13:0], vec_mem[w+3][7:0]};
            @(posedge clk_sys);
            rom_load <= '0;
          end
          2: begin
            @(posedge clk_sys);
            host <= {1'b1, vec_mem[w+2][15:0], vec_mem[w+3][7:0]};
            @(posedge clk_sys);
            host <= '0;
          end
          4: begin
            @(posedge clk_sys);
            hflip <= vec_mem[w+2][0];
            vflip <= vec_mem[w+3][0];
          end
          default: ;
        endcase
      end
    end
  endtask

  always @(negedge clk_sys) begin
    if (rst_n) begin
      cycle++;
      if (hsync && !prev_hsync) begin
        if (last_hsync >= 0) begin
          check("hsync period", cycle - last_hsync, H_TOTAL);
        end
        last_hsync = cycle;
      end
      if (vsync && !prev_vsync) begin
        if (last_vsync >= 0) begin
          check("vsync period", cycle - last_vsync, H_TOTAL * V_TOTAL);
        end
        last_vsync = cycle;
      end
      if (!hblank && prev_hblank) begin
        line_open  = 1'b1;
        active_len = 0;
      end
      if (hblank && !prev_hblank) begin
        if (line_open) begin
          check("hblank low length", active_len, H_ACTIVE);
        end
        x_pos = 0;
        y_pos++;
      end
      if (!vblank && prev_vblank) begin
        cap_frame++;
        x_pos = 0;
        y_pos = 0;
      end
      if (hsync) begin
        check("hblank", hblank, 1'b1);
      end
      if (vsync) begin
        check("vblank", vblank, 1'b1);
      end
      if (!hblank) begin
        active_len++;
      end
      if (hblank || vblank) begin
        check("red", red, 8'h00);
        check("green", green, 8'h00);
        check("blue", blue, 8'h00);
      end else begin
        for (int i = 0; i < n_exp; i++) begin
          if (exp_frame[i] == cap_frame && exp_x[i] == x_pos && exp_y[i] == y_pos) begin
            exp_seen[i] = 1'b1;
            check("red", red, {exp_rgb[i][11:8], 4'h0});
            check("green", green, {exp_rgb[i][7:4], 4'h0});
            check("blue", blue, {exp_rgb[i][3:0], 4'h0});
          end
        end
        x_pos++;
      end
      prev_hblank = hblank;
      prev_vblank = vblank;
      prev_hsync  = hsync;
      prev_vsync  = vsync;
    end
  end

  initial begin
    clk_sys  = 1'b0;
    rst_n    = 1'b0;
    host     = '0;
    rom_load = '0;
    hflip    = 1'b0;
    vflip    = 1'b0;
    load_vectors();
    vectors_ready = 1'b1;
    if (n_exp == 0) begin
      errors++;
      $display("ERROR: the vector file holds no expected pixels");
    end
    repeat (4) @(posedge clk_sys);
    rst_n <= 1'b1;
    apply_setup(0);
    for (int f = 1; f <= n_frames; f++) begin
      wait (cap_frame == f - 1);
      @(posedge vblank);
      if (f < n_frames) begin
        apply_setup(f);
      end
    end
    for (int i = 0; i < n_exp; i++) begin
      if (!exp_seen[i]) begin
        errors++;
        $display("ERROR: pixel (%0d, %0d) of frame %0d was never displayed",
                 exp_x[i], exp_y[i], exp_frame[i]);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Two passes over the vector frames and the frame after reset
  initial begin
    longint limit;
    wait (vectors_ready);
    limit = 2 * longint'(n_frames + 1) * H_TOTAL * V_TOTAL * CLK_PERIOD;
    #(limit);
    $display("ERROR: timeout, the run did not end within %0d ns", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/mylstar_video_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module mylstar_video_chk (
  input wire       clk_sys,
  input wire       rst_n,
  input wire [7:0] red,
  input wire [7:0] green,
  input wire [7:0] blue,
  input wire       hsync,
  input wire       vsync,
  input wire       hblank,
  input wire       vblank
);

  // Sync pulses sit inside blanking
  hsync_in_hblank: assert property (@(posedge clk_sys) disable iff (!rst_n) hsync |-> hblank)
    else $error("hsync high outside horizontal blank");

  vsync_in_vblank: assert property (@(posedge clk_sys) disable iff (!rst_n) vsync |-> vblank)
    else $error("vsync high outside vertical blank");

  blank_is_black: assert property (@(posedge clk_sys) disable iff (!rst_n)
    (hblank || vblank) |-> (red == 8'd0 && green == 8'd0 && blue == 8'd0))
    else $error("colour output not black during blank");

endmodule

bind mylstar_video mylstar_video_chk u_chk (
  .clk_sys (clk_sys),
  .rst_n   (rst_n),
  .red     (red),
  .green   (green),
  .blue    (blue),
  .hsync   (hsync),
  .vsync   (vsync),
  .hblank  (hblank),
  .vblank  (vblank)
);

`default_nettype wire

// ==== src/mylstar_video.sv ====
`timescale 1ns/10ps
`default_nettype none

module mylstar_video
  import mylstar_pkg::*;
#(
  parameter int H_ACTIVE    = mylstar_pkg::H_ACTIVE,
  parameter int H_TOTAL     = mylstar_pkg::H_TOTAL,
  parameter int HSYNC_START = mylstar_pkg::HSYNC_START,
  parameter int HSYNC_LEN   = mylstar_pkg::HSYNC_LEN,
  parameter int V_ACTIVE    = mylstar_pkg::V_ACTIVE,
  parameter int V_TOTAL     = mylstar_pkg::V_TOTAL,
  parameter int VSYNC_START = mylstar_pkg::VSYNC_START,
  parameter int VSYNC_LEN   = mylstar_pkg::VSYNC_LEN
) (
  input  wire        clk_sys,
  input  wire        rst_n,
  input  host_wr_t   host,
  input  rom_load_t  rom_load,
  input  wire        hflip,
  input  wire        vflip,
  output logic [7:0] red,
  output logic [7:0] green,
  output logic [7:0] blue,
  output logic       hsync,
  output logic       vsync,
  output logic       hblank,
  output logic       vblank
);

  beam_t      beam;
  beam_t      beam_px;
  ctrl_t      ctrl;
  map_wr_t    map_wr;
  pal_wr_t    pal_wr;
  logic [3:0] pix_index;

  video_timing #(
    .H_ACTIVE    (H_ACTIVE),
    .H_TOTAL     (H_TOTAL),
    .HSYNC_START (HSYNC_START),
    .HSYNC_LEN   (HSYNC_LEN),
    .V_ACTIVE    (V_ACTIVE),
    .V_TOTAL     (V_TOTAL),
    .VSYNC_START (VSYNC_START),
    .VSYNC_LEN   (VSYNC_LEN)
  ) u_timing (
    .clk_sys (clk_sys),
    .rst_n   (rst_n),
    .beam    (beam)
  );

  host_decode u_decode (
    .clk_sys (clk_sys),
    .rst_n   (rst_n),
    .host    (host),
    .hflip   (hflip),
    .vflip   (vflip),
    .ctrl    (ctrl),
    .map_wr  (map_wr),
    .pal_wr  (pal_wr)
  );

  bg_tile_render u_bg (
    .clk_sys   (clk_sys),
    .rst_n     (rst_n),
    .beam      (beam),
    .ctrl      (ctrl),
    .map_wr    (map_wr),
    .rom_load  (rom_load),
    .pix_index (pix_index),
    .beam_out  (beam_px)
  );

  palette_lut u_palette (
    .clk_sys   (clk_sys),
    .rst_n     (rst_n),
    .pal_wr    (pal_wr),
    .pix_index (pix_index),
    .beam_in   (beam_px),
    .red       (red),
    .green     (green),
    .blue      (blue),
    .hsync     (hsync),
    .vsync     (vsync),
    .hblank    (hblank),
    .vblank    (vblank)
  );

endmodule

`default_nettype wire

// ==== src/palette_lut.sv ====
`timescale 1ns/10ps
`default_nettype none

module palette_lut
  import mylstar_pkg::*;
(
  input  wire        clk_sys,
  input  wire        rst_n,
  input  pal_wr_t    pal_wr,
  input  wire  [3:0] pix_index,
  input  beam_t      beam_in,
  output logic [7:0] red,
  output logic [7:0] green,
  output logic [7:0] blue,
  output logic       hsync,
  output logic       vsync,
  output logic       hblank,
  output logic       vblank
);

  // Entry layout is red, green, blue
  logic [11:0] pal_ram [16];
  logic [11:0] colour;

  always_ff @(posedge clk_sys) begin
    if (pal_wr.wr_r) begin
      pal_ram[pal_wr.entry][11:8] <= pal_wr.data[3:0];
    end
    if (pal_wr.wr_gb) begin
      pal_ram[pal_wr.entry][7:0] <= pal_wr.data;
    end
  end

  assign colour = pal_ram[pix_index];

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      red    <= '0;
      green  <= '0;
      blue   <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblank <= 1'b0;
      vblank <= 1'b0;
    end else begin
      if (beam_in.hblank || beam_in.vblank) begin
        red   <= '0;
        green <= '0;
        blue  <= '0;
      end else begin
        red   <= {colour[11:8], 4'd0};
        green <= {colour[7:4], 4'd0};
        blue  <= {colour[3:0], 4'd0};
      end
      hsync  <= beam_in.hsync;
      vsync  <= beam_in.vsync;
      hblank <= beam_in.hblank;
      vblank <= beam_in.vblank;
    end
  end

endmodule

`default_nettype wire

// ==== bg/bg_tile_render.sv ====
`timescale 1ns/10ps
`default_nettype none

module bg_tile_render
  import mylstar_pkg::*;
(
  input  wire        clk_sys,
  input  wire        rst_n,
  input  beam_t      beam,
  input  ctrl_t      ctrl,
  input  map_wr_t    map_wr,
  input  rom_load_t  rom_load,
  output logic [3:0] pix_index,
  output beam_t      beam_out
);

  localparam int STAGES = PIPE_DEPTH - 1;

  logic [7:0] map_ram [1024];
  logic [7:0] tile_rom [16384];

  logic [7:0] col;
  logic [7:0] row;

  logic [7:0] tile_code;
  logic [2:0] row_s1;
  logic [2:0] col_s1;

  logic [7:0] rom_byte;
  logic       col0_s2;

  beam_t      beam_d [STAGES];

  // Screen flip is applied to the fetch coordinates
  assign col = beam.h[7:0] ^ {8{ctrl.hflip}};
  assign row = beam.v[7:0] ^ {8{ctrl.vflip}};

  // Stage 1: map lookup, 32 tiles per row
  always_ff @(posedge clk_sys) begin
    if (map_wr.wr) begin
      map_ram[map_wr.idx] <= map_wr.code;
    end
    tile_code <= map_ram[{row[7:3], col[7:3]}];
    row_s1    <= row[2:0];
    col_s1    <= col[2:0];
  end

  // Stage 2: tile ROM, two pixels per byte
  always_ff @(posedge clk_sys) begin
    if (rom_load.valid) begin
      tile_rom[rom_load.addr] <= rom_load.data;
    end
    rom_byte <= tile_rom[{ctrl.bank_sel, tile_code, row_s1, col_s1[2:1]}];
    col0_s2  <= col_s1[0];
  end

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      beam_d <= '{default: '0};
    end else begin
      beam_d[0] <= beam;
      for (int i = 1; i < STAGES; i++) begin
        beam_d[i] <= beam_d[i-1];
      end
    end
  end

  assign beam_out = beam_d[STAGES-1];

  // Even pixel sits in the low nibble
  always_comb begin
    if (beam_out.hblank || beam_out.vblank) begin
      pix_index = 4'd0;
    end else if (col0_s2) begin
      pix_index = rom_byte[7:4];
    end else begin
      pix_index = rom_byte[3:0];
    end
  end

endmodule

`default_nettype wire

// ==== src/host_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module host_decode
  import mylstar_pkg::*;
(
  input  wire      clk_sys,
  input  wire      rst_n,
  input  host_wr_t host,
  input  wire      hflip,
  input  wire      vflip,
  output ctrl_t    ctrl,
  output map_wr_t  map_wr,
  output pal_wr_t  pal_wr
);

  bus_region_e region;
  ctrl_t       ctrl_q;

  always_comb begin
    if (host.addr[15:10] == MAP_BASE[15:10]) begin
      region = REGION_MAP;
    end else if (host.addr[15:5] == PAL_BASE[15:5]) begin
      region = REGION_PAL;
    end else if (host.addr == CTRL_ADDR) begin
      region = REGION_CTRL;
    end else begin
      region = REGION_NONE;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      ctrl_q <= '0;
    end else if (host.wr && region == REGION_CTRL) begin
      ctrl_q.hflip    <= host.data[CTRL_HFLIP_BIT];
      ctrl_q.vflip    <= host.data[CTRL_VFLIP_BIT];
      ctrl_q.bank_sel <= host.data[CTRL_BANK_BIT];
    end
  end

  // Cabinet pins invert the register flip bits
  assign ctrl.hflip    = ctrl_q.hflip ^ hflip;
  assign ctrl.vflip    = ctrl_q.vflip ^ vflip;
  assign ctrl.bank_sel = ctrl_q.bank_sel;

  assign map_wr.wr   = host.wr && (region == REGION_MAP);
  assign map_wr.idx  = host.addr[9:0];
  assign map_wr.code = host.data;

  // Odd byte is red, even byte is green and blue
  assign pal_wr.wr_r  = host.wr && (region == REGION_PAL) && host.addr[0];
  assign pal_wr.wr_gb = host.wr && (region == REGION_PAL) && !host.addr[0];
  assign pal_wr.entry = host.addr[4:1];
  assign pal_wr.data  = host.data;

endmodule

`default_nettype wire

// ==== src/video_timing.sv ====
`timescale 1ns/10ps
`default_nettype none

module video_timing
  import mylstar_pkg::*;
#(
  parameter int H_ACTIVE    = 256,
  parameter int H_TOTAL     = 320,
  parameter int HSYNC_START = 272,
  parameter int HSYNC_LEN   = 24,
  parameter int V_ACTIVE    = 240,
  parameter int V_TOTAL     = 262,
  parameter int VSYNC_START = 244,
  parameter int VSYNC_LEN   = 3
) (
  input  wire   clk_sys,
  input  wire   rst_n,
  output beam_t beam
);

  localparam logic [8:0] H_LAST     = 9'(H_TOTAL - 1);
  localparam logic [8:0] V_LAST     = 9'(V_TOTAL - 1);
  localparam logic [8:0] H_ACT      = 9'(H_ACTIVE);
  localparam logic [8:0] V_ACT      = 9'(V_ACTIVE);
  localparam logic [8:0] HS_FIRST   = 9'(HSYNC_START);
  localparam logic [8:0] HS_END     = 9'(HSYNC_START + HSYNC_LEN);
  localparam logic [8:0] VS_FIRST   = 9'(VSYNC_START);
  localparam logic [8:0] VS_END     = 9'(VSYNC_START + VSYNC_LEN);

  logic [8:0] h_next;
  logic [8:0] v_next;

  // Horizontal counter carries into the line counter
  always_comb begin
    h_next = beam.h + 9'd1;
    v_next = beam.v;
    if (beam.h == H_LAST) begin
      h_next = 9'd0;
      if (beam.v == V_LAST) begin
        v_next = 9'd0;
      end else begin
        v_next = beam.v + 9'd1;
      end
    end
  end

  // Flags are decoded from the next count so they register with it
  always_ff @(posedge clk_sys) begin
    if (!rst_n) begin
      beam <= '0;
    end else begin
      beam.h      <= h_next;
      beam.v      <= v_next;
      beam.hblank <= (h_next >= H_ACT);
      beam.vblank <= (v_next >= V_ACT);
      beam.hsync  <= (h_next >= HS_FIRST) && (h_next < HS_END);
      beam.vsync  <= (v_next >= VS_FIRST) && (v_next < VS_END);
    end
  end

endmodule

`default_nettype wire

// ==== common/mylstar_pkg.sv ====
`default_nettype none

package mylstar_pkg;

  // Host write cycle, one per strobe
  typedef struct packed {
    logic        wr;
    logic [15:0] addr;
    logic [7:0]  data;
  } host_wr_t;

  // Tile ROM download beat
  typedef struct packed {
    logic        valid;
    logic [13:0] addr;
    logic [7:0]  data;
  } rom_load_t;

  // Scan position and video flags
  typedef struct packed {
    logic [8:0] h;
    logic [8:0] v;
    logic       hblank;
    logic       vblank;
    logic       hsync;
    logic       vsync;
  } beam_t;

  // Effective flip and bank state
  typedef struct packed {
    logic hflip;
    logic vflip;
    logic bank_sel;
  } ctrl_t;

  typedef struct packed {
    logic       wr_r;
    logic       wr_gb;
    logic [3:0] entry;
    logic [7:0] data;
  } pal_wr_t;

  typedef struct packed {
    logic       wr;
    logic [9:0] idx;
    logic [7:0] code;
  } map_wr_t;

  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_MAP,
    REGION_PAL,
    REGION_CTRL
  } bus_region_e;

  // Host address map
  localparam logic [15:0] MAP_BASE  = 16'h4000;
  localparam logic [15:0] PAL_BASE  = 16'h5000;
  localparam logic [15:0] CTRL_ADDR = 16'h5800;

  // Control register layout
  localparam int CTRL_HFLIP_BIT = 1;
  localparam int CTRL_VFLIP_BIT = 2;
  localparam int CTRL_BANK_BIT  = 4;

  // Default raster
  localparam int H_ACTIVE    = 256;
  localparam int H_TOTAL     = 320;
  localparam int HSYNC_START = 272;
  localparam int HSYNC_LEN   = 24;
  localparam int V_ACTIVE    = 240;
  localparam int V_TOTAL     = 262;
  localparam int VSYNC_START = 244;
  localparam int VSYNC_LEN   = 3;

  // Beam register to RGB output
  localparam int PIPE_DEPTH = 3;

endpackage

`default_nettype wire
